// ==== design/bpm_pkg.sv ====
package bpm_pkg;

	////////////////////////////////
	// Widths and constants
	////////////////////////////////
	localparam int data_width = 16;
	localparam int bus_width = 32;
	localparam int num_ch = 4;                    // Pickup channels A to D
	localparam int map_idx_bits = 7;              // 128 words in the map
	localparam logic [bus_width-1:0] base_addr = 32'h41710000;
	localparam logic [bus_width-1:0] fpga_version = 32'h0002_0007;

	localparam int att_bits = 6;                  // Serial attenuator setting
	localparam int vga_bits = 5;

	////////////////////////////////
	// Register indices, word address = base + 4 * index
	////////////////////////////////
	localparam logic [map_idx_bits-1:0] idx_sr = 7'd0;
	localparam logic [map_idx_bits-1:0] idx_cr = 7'd1;
	localparam logic [map_idx_bits-1:0] idx_version = 7'd2;
	localparam logic [map_idx_bits-1:0] idx_pwr_a = 7'd4;
	localparam logic [map_idx_bits-1:0] idx_pwr_b = 7'd5;
	localparam logic [map_idx_bits-1:0] idx_pwr_c = 7'd6;
	localparam logic [map_idx_bits-1:0] idx_pwr_d = 7'd7;
	localparam logic [map_idx_bits-1:0] idx_x = 7'd8;
	localparam logic [map_idx_bits-1:0] idx_y = 7'd9;
	localparam logic [map_idx_bits-1:0] idx_s = 7'd10;
	localparam logic [map_idx_bits-1:0] idx_trig_dl = 7'd22;
	localparam logic [map_idx_bits-1:0] idx_bpm_dia = 7'd23;
	localparam logic [map_idx_bits-1:0] idx_trig_th = 7'd24;
	localparam logic [map_idx_bits-1:0] idx_trig_dt = 7'd25;
	localparam logic [map_idx_bits-1:0] idx_evt_len = 7'd26;
	localparam logic [map_idx_bits-1:0] idx_evt_tail_len = 7'd27;
	localparam logic [map_idx_bits-1:0] idx_bl_len = 7'd28;
	localparam logic [map_idx_bits-1:0] idx_afe_ctrl = 7'd88;
	localparam logic [map_idx_bits-1:0] idx_gain_a = 7'd96;
	localparam logic [map_idx_bits-1:0] idx_gain_b = 7'd97;
	localparam logic [map_idx_bits-1:0] idx_gain_c = 7'd98;
	localparam logic [map_idx_bits-1:0] idx_gain_d = 7'd99;

	// Control word bits
	localparam int cr_sma_en = 3;
	localparam int cr_auto_range = 6;             // 1 selects auto VGA gain
	localparam int cr_cal_off = 13;
	localparam int cr_soft_rst = 15;

	typedef struct packed {
		logic en;
		logic [3:0] we;                           // All ones write, zero read
		logic [bus_width-1:0] addr;
		logic [bus_width-1:0] wr_data;
	} bus_req_t;

	typedef enum logic [4:0] {
		sel_none, sel_sr, sel_cr, sel_version,
		sel_pwr_a, sel_pwr_b, sel_pwr_c, sel_pwr_d,
		sel_x, sel_y, sel_s,
		sel_trig_dl, sel_bpm_dia, sel_trig_th, sel_trig_dt,
		sel_evt_len, sel_evt_tail_len, sel_bl_len, sel_afe_ctrl,
		sel_gain_a, sel_gain_b, sel_gain_c, sel_gain_d
	} reg_sel_e;

	typedef struct packed {
		logic cr;
		logic afe_ctrl;
		logic bpm_dia;
		logic trig_th;
		logic trig_dt;
		logic trig_dl;
		logic evt_len;
		logic evt_tail_len;
		logic bl_len;
		logic [num_ch-1:0] gain;
	} wr_strobe_t;

	// AFE control fields
	typedef struct packed {
		logic [1:0] spare_hi;
		logic [att_bits-1:0] att;                 // Bits 13:8
		logic [2:0] spare_lo;
		logic [vga_bits-1:0] vga;                 // Bits 4:0
	} afe_ctrl_f_t;

	typedef union packed {
		logic [data_width-1:0] raw;
		afe_ctrl_f_t f;
	} afe_ctrl_u;

	typedef struct packed {
		logic [data_width-1:0] ctrl;
		afe_ctrl_u afe;
		logic [data_width-1:0] bpm_dia;
		logic [data_width-1:0] trig_th;
		logic [data_width-1:0] trig_dt;
		logic [data_width-1:0] trig_dl;
		logic [data_width-1:0] evt_len;
		logic [data_width-1:0] evt_tail_len;
		logic [data_width-1:0] bl_len;
		logic [num_ch-1:0][bus_width-1:0] gain;
	} bpm_cfg_t;

	typedef struct packed {
		logic [num_ch-1:0][bus_width-1:0] pwr;    // Index 0 is channel A
		logic [data_width-1:0] x;
		logic [data_width-1:0] y;
		logic [data_width-1:0] s;
		logic [data_width-1:0] status;
	} meas_t;

endpackage

// ==== design/bpm_bus_ctrl.sv ====
`timescale 1ns/100ps

module bpm_bus_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  bpm_pkg::bus_req_t bus,
	output bpm_pkg::wr_strobe_t wr,
	output bpm_pkg::reg_sel_e rd_sel
);
	import bpm_pkg::*;

	logic [bus_width-1:0] offset;
	logic in_range;
	logic [map_idx_bits-1:0] idx;
	logic wr_ok;
	logic rd_ok;

	// Word index relative to the base, anything outside the map is dropped
	assign offset = bus.addr - base_addr;
	assign in_range = (offset[bus_width-1:map_idx_bits+2] == '0) && (offset[1:0] == 2'b00);
	assign idx = offset[map_idx_bits+1:2];

	assign wr_ok = bus.en && (bus.we == 4'hf) && in_range;
	assign rd_ok = bus.en && (bus.we == 4'h0) && in_range;   // Partial we is ignored

	always_comb begin
		wr = '0;
		if (wr_ok) begin
			case (idx)
				idx_cr: wr.cr = 1'b1;
				idx_afe_ctrl: wr.afe_ctrl = 1'b1;
				idx_bpm_dia: wr.bpm_dia = 1'b1;
				idx_trig_th: wr.trig_th = 1'b1;
				idx_trig_dt: wr.trig_dt = 1'b1;
				idx_trig_dl: wr.trig_dl = 1'b1;
				idx_evt_len: wr.evt_len = 1'b1;
				idx_evt_tail_len: wr.evt_tail_len = 1'b1;
				idx_bl_len: wr.bl_len = 1'b1;
				idx_gain_a: wr.gain[0] = 1'b1;
				idx_gain_b: wr.gain[1] = 1'b1;
				idx_gain_c: wr.gain[2] = 1'b1;
				idx_gain_d: wr.gain[3] = 1'b1;
				default: wr = '0;                 // Read-only or unmapped
			endcase
		end
	end

	always_comb begin
		rd_sel = sel_none;
		if (rd_ok) begin
			case (idx)
				idx_sr: rd_sel = sel_sr;
				idx_cr: rd_sel = sel_cr;
				idx_version: rd_sel = sel_version;
				idx_pwr_a: rd_sel = sel_pwr_a;
				idx_pwr_b: rd_sel = sel_pwr_b;
				idx_pwr_c: rd_sel = sel_pwr_c;
				idx_pwr_d: rd_sel = sel_pwr_d;
				idx_x: rd_sel = sel_x;
				idx_y: rd_sel = sel_y;
				idx_s: rd_sel = sel_s;
				idx_trig_dl: rd_sel = sel_trig_dl;
				idx_bpm_dia: rd_sel = sel_bpm_dia;
				idx_trig_th: rd_sel = sel_trig_th;
				idx_trig_dt: rd_sel = sel_trig_dt;
				idx_evt_len: rd_sel = sel_evt_len;
				idx_evt_tail_len: rd_sel = sel_evt_tail_len;
				idx_bl_len: rd_sel = sel_bl_len;
				idx_afe_ctrl: rd_sel = sel_afe_ctrl;
				idx_gain_a: rd_sel = sel_gain_a;
				idx_gain_b: rd_sel = sel_gain_b;
				idx_gain_c: rd_sel = sel_gain_c;
				idx_gain_d: rd_sel = sel_gain_d;
				default: rd_sel = sel_none;
			endcase
		end
	end

	// One register per access, and never a write and a read together
	a_one_access: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(wr) && !((|wr) && (rd_sel != sel_none)));

endmodule

// ==== design/bpm_config_regs.sv ====
`timescale 1ns/100ps

module bpm_config_regs (
	input  logic clk,
	input  logic rst_n,
	input  bpm_pkg::wr_strobe_t wr,
	input  logic [bpm_pkg::bus_width-1:0] wr_data,
	output bpm_pkg::bpm_cfg_t cfg,
	output logic soft_rst
);
	import bpm_pkg::*;

	logic [data_width-1:0] wr_half;

	assign wr_half = wr_data[data_width-1:0];    // 16-bit registers use the low half

	////////////////////////////////
	// Register file
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg <= '0;
		end else begin
			if (wr.cr) cfg.ctrl <= wr_half;
			if (wr.afe_ctrl) cfg.afe.raw <= wr_half;
			if (wr.bpm_dia) cfg.bpm_dia <= wr_half;
			if (wr.trig_th) cfg.trig_th <= wr_half;
			if (wr.trig_dt) cfg.trig_dt <= wr_half;
			if (wr.trig_dl) cfg.trig_dl <= wr_half;
			if (wr.evt_len) cfg.evt_len <= wr_half;
			if (wr.evt_tail_len) cfg.evt_tail_len <= wr_half;
			if (wr.bl_len) cfg.bl_len <= wr_half;

			// Channel gains are full words
			for (int i = 0; i < num_ch; i++) begin
				if (wr.gain[i]) cfg.gain[i] <= wr_data;
			end
		end
	end

	// Soft reset lags control bit 15 by a cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			soft_rst <= 1'b0;
		end else begin
			soft_rst <= cfg.ctrl[cr_soft_rst];
		end
	end

endmodule

// ==== design/bpm_readback.sv ====
`timescale 1ns/100ps

module bpm_readback (
	input  logic clk,
	input  logic rst_n,
	input  bpm_pkg::reg_sel_e rd_sel,
	input  bpm_pkg::bpm_cfg_t cfg,
	input  bpm_pkg::meas_t meas,
	output logic [bpm_pkg::bus_width-1:0] rd_data
);
	import bpm_pkg::*;

	function automatic logic [bus_width-1:0] sext(input logic [data_width-1:0] w);
		return {{(bus_width-data_width){w[data_width-1]}}, w};
	endfunction

	function automatic logic [bus_width-1:0] zext(input logic [data_width-1:0] w);
		return {{(bus_width-data_width){1'b0}}, w};
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_data <= '0;
		end else begin
			case (rd_sel)
				// Signed words
				sel_sr: rd_data <= sext(meas.status);
				sel_cr: rd_data <= sext(cfg.ctrl);
				sel_afe_ctrl: rd_data <= sext(cfg.afe.raw);
				sel_version: rd_data <= fpga_version;
				sel_pwr_a: rd_data <= meas.pwr[0];
				sel_pwr_b: rd_data <= meas.pwr[1];
				sel_pwr_c: rd_data <= meas.pwr[2];
				sel_pwr_d: rd_data <= meas.pwr[3];
				sel_x: rd_data <= zext(meas.x);
				sel_y: rd_data <= zext(meas.y);
				sel_s: rd_data <= zext(meas.s);
				sel_trig_dl: rd_data <= zext(cfg.trig_dl);
				sel_bpm_dia: rd_data <= zext(cfg.bpm_dia);
				sel_trig_th: rd_data <= zext(cfg.trig_th);
				sel_trig_dt: rd_data <= zext(cfg.trig_dt);
				sel_evt_len: rd_data <= zext(cfg.evt_len);
				sel_evt_tail_len: rd_data <= zext(cfg.evt_tail_len);
				sel_bl_len: rd_data <= zext(cfg.bl_len);
				sel_gain_a: rd_data <= cfg.gain[0];
				sel_gain_b: rd_data <= cfg.gain[1];
				sel_gain_c: rd_data <= cfg.gain[2];
				sel_gain_d: rd_data <= cfg.gain[3];
				default: rd_data <= rd_data;      // Keep the last word
			endcase
		end
	end

endmodule

// ==== design/bpm_afe_ctrl.sv ====
`timescale 1ns/100ps

module bpm_afe_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  bpm_pkg::bpm_cfg_t cfg,
	input  logic trig_out,
	input  logic cal_on,
	input  logic [bpm_pkg::vga_bits-1:0] auto_gain,
	output logic att_le,
	output logic att_clk,
	output logic att_data,
	output logic sma_out,
	output logic afe_pickup,
	output logic afe_cal,
	output logic [bpm_pkg::vga_bits-1:0] afe_vga_gain
);
	import bpm_pkg::*;

	logic [att_bits-1:0] last_sent;               // Value of the last transfer
	logic [att_bits-1:0] shreg;
	logic [$clog2(2*att_bits)-1:0] phase_cnt;     // Two phases per bit
	logic shifting;
	logic changed;
	logic last_phase;

	assign changed = (cfg.afe.f.att != last_sent);
	assign last_phase = (phase_cnt == ($bits(phase_cnt))'(2*att_bits-1));

	////////////////////////////////
	// Attenuator serial writer
	////////////////////////////////
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_sent <= '0;
			shreg <= '0;
			phase_cnt <= '0;
			shifting <= 1'b0;
			att_le <= 1'b0;
		end else begin
			att_le <= 1'b0;
			if (shifting) begin
				phase_cnt <= phase_cnt + 1'b1;
				if (last_phase) begin
					shifting <= 1'b0;
					att_le <= 1'b1;               // Latch pulse closes the transfer
				end else if (phase_cnt[0]) begin
					shreg <= shreg << 1;          // Next bit after clock high
				end
			end else if (!att_le && changed) begin
				// Pick up the latest setting, even one written mid-transfer
				shreg <= cfg.afe.f.att;
				last_sent <= cfg.afe.f.att;
				phase_cnt <= '0;
				shifting <= 1'b1;
			end
		end
	end

	assign att_clk = shifting & phase_cnt[0];     // Low then high for each bit
	assign att_data = shifting & shreg[att_bits-1];   // MSB first

	////////////////////////////////
	// Path select, VGA and SMA
	////////////////////////////////
	assign afe_pickup = cfg.ctrl[cr_cal_off] ? 1'b1 : cal_on;
	assign afe_cal = ~afe_pickup;

	// Board has an inverting gate on the SMA path
	assign sma_out = cfg.ctrl[cr_sma_en] ? ~trig_out : 1'b1;

	assign afe_vga_gain = cfg.ctrl[cr_auto_range] ? auto_gain : cfg.afe.f.vga;

	// Latch only after the last clock high, never alongside it
	a_att_le: assert property (@(posedge clk) disable iff (!rst_n)
		att_le |-> (!att_clk && $past(att_clk)));

endmodule

// ==== design/bpm_top.sv ====
`timescale 1ns/100ps

module bpm_top (
	input  logic clk,
	input  logic rst_n,
	input  bpm_pkg::bus_req_t bus,
	output logic [bpm_pkg::bus_width-1:0] rd_data,
	input  bpm_pkg::meas_t meas,
	input  logic trig_out,
	input  logic cal_on,
	input  logic [bpm_pkg::vga_bits-1:0] auto_gain,
	output bpm_pkg::bpm_cfg_t cfg,                // To the signal processing block
	output logic soft_rst,
	output logic att_le,
	output logic att_clk,
	output logic att_data,
	output logic sma_out,
	output logic afe_pickup,
	output logic afe_cal,
	output logic [bpm_pkg::vga_bits-1:0] afe_vga_gain
);
	import bpm_pkg::*;

	wr_strobe_t wr;
	reg_sel_e rd_sel;

	////////////////////////////////
	// Processor port
	////////////////////////////////
	bpm_bus_ctrl u_bus_ctrl (
		.clk    (clk),
		.rst_n  (rst_n),
		.bus    (bus),
		.wr     (wr),
		.rd_sel (rd_sel)
	);

	bpm_config_regs u_config_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (wr),
		.wr_data  (bus.wr_data),
		.cfg      (cfg),
		.soft_rst (soft_rst)
	);

	bpm_readback u_readback (
		.clk     (clk),
		.rst_n   (rst_n),
		.rd_sel  (rd_sel),
		.cfg     (cfg),
		.meas    (meas),
		.rd_data (rd_data)
	);

	// Front-end pins
	bpm_afe_ctrl u_afe_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.trig_out     (trig_out),
		.cal_on       (cal_on),
		.auto_gain    (auto_gain),
		.att_le       (att_le),
		.att_clk      (att_clk),
		.att_data     (att_data),
		.sma_out      (sma_out),
		.afe_pickup   (afe_pickup),
		.afe_cal      (afe_cal),
		.afe_vga_gain (afe_vga_gain)
	);

endmodule

// ==== verif/tb_bpm_top.sv ====
`timescale 1ns/100ps

module tb_bpm_top;
	import bpm_pkg::*;

	logic clk;
	logic rst_n;
	bus_req_t bus;
	meas_t meas;
	logic trig_out;
	logic cal_on;
	logic [vga_bits-1:0] auto_gain;
	logic [bus_width-1:0] rd_data;
	bpm_cfg_t cfg;
	logic soft_rst;
	logic att_le;
	logic att_clk;
	logic att_data;
	logic sma_out;
	logic afe_pickup;
	logic afe_cal;
	logic [vga_bits-1:0] afe_vga_gain;

	logic [31:0] lfsr;
	logic [bus_width-1:0] shadow [0:127];        // Last word written per index
	logic [bus_width-1:0] last_rd;
	logic [bus_width-1:0] exp_q [$];
	int regs16 [9] = '{1, 22, 23, 24, 25, 26, 27, 28, 88};
	int check_count;
	int err_count;
	int timeout_count;
	logic [att_bits-1:0] att_cap;
	logic [att_bits-1:0] att_latched;
	int att_nbits;
	int le_count;
	logic att_clk_q;
	logic soft_exp;

	initial clk = 1'b0;
	always #50 clk = ~clk;

	bpm_top uut (
		.clk (clk), .rst_n (rst_n), .bus (bus), .rd_data (rd_data), .meas (meas),
		.trig_out (trig_out), .cal_on (cal_on), .auto_gain (auto_gain), .cfg (cfg),
		.soft_rst (soft_rst), .att_le (att_le), .att_clk (att_clk), .att_data (att_data),
		.sma_out (sma_out), .afe_pickup (afe_pickup), .afe_cal (afe_cal),
		.afe_vga_gain (afe_vga_gain)
	);

	//////////////////////////////
	// Reference model
	//////////////////////////////
	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [bus_width-1:0] reg_addr(input int idx);
		return base_addr + 32'(idx * 4);
	endfunction

	function automatic bit is_writable(input int idx);
		return (idx == 1) || (idx >= 22 && idx <= 28) || (idx == 88) || (idx >= 96 && idx <= 99);
	endfunction

	function automatic logic [bus_width-1:0] expected_read(input logic [bus_width-1:0] addr);
		logic [bus_width-1:0] off;
		int idx;
		off = addr - base_addr;
		if (off >= 32'd512 || off[1:0] != 2'b00) return last_rd;   // Outside the map
		idx = int'(off >> 2);
		case (idx)
			0: return {{16{meas.status[15]}}, meas.status};
			1, 88: return {{16{shadow[idx][15]}}, shadow[idx][15:0]};
			2: return fpga_version;
			4, 5, 6, 7: return meas.pwr[idx-4];
			8: return {16'h0, meas.x};
			9: return {16'h0, meas.y};
			10: return {16'h0, meas.s};
			22, 23, 24, 25, 26, 27, 28: return {16'h0, shadow[idx][15:0]};
			96, 97, 98, 99: return shadow[idx];
			default: return last_rd;
		endcase
	endfunction

	function automatic bpm_cfg_t expected_cfg();
		bpm_cfg_t c;
		c.ctrl = shadow[1][15:0];
		c.afe.raw = shadow[88][15:0];
		c.bpm_dia = shadow[23][15:0];
		c.trig_th = shadow[24][15:0];
		c.trig_dt = shadow[25][15:0];
		c.trig_dl = shadow[22][15:0];
		c.evt_len = shadow[26][15:0];
		c.evt_tail_len = shadow[27][15:0];
		c.bl_len = shadow[28][15:0];
		for (int i = 0; i < 4; i++) c.gain[i] = shadow[96+i];
		return c;
	endfunction

	//////////////////////////////
	// Bus and pin tasks
	//////////////////////////////
	task automatic bus_write(input int idx, input logic [3:0] we, input logic [31:0] data);
		@(posedge clk);
		bus <= '{en: 1'b1, we: we, addr: reg_addr(idx), wr_data: data};
		@(posedge clk);
		bus.en <= 1'b0;
		if (we == 4'hf && is_writable(idx)) shadow[idx] = (idx >= 96) ? data : {16'h0, data[15:0]};
		@(negedge clk);
		check_count++;
		assert (cfg === expected_cfg()) else begin
			$display("Fail %0t: cfg differs after write to index %0d", $time, idx);
			err_count++;
		end
	endtask

	task automatic bus_read(input logic [bus_width-1:0] addr);
		@(posedge clk);
		bus <= '{en: 1'b1, we: 4'h0, addr: addr, wr_data: rand_bits(32)};
		@(posedge clk);                           // Access sampled here
		bus.en <= 1'b0;
		last_rd = expected_read(addr);
		exp_q.push_back(last_rd);
	endtask

	task automatic drive_meas();
		meas_t m;
		for (int i = 0; i < 4; i++) m.pwr[i] = rand_bits(32);
		m.x = 16'(rand_bits(16));
		m.y = 16'(rand_bits(16));
		m.s = 16'(rand_bits(16));
		m.status = 16'(rand_bits(16));
		@(posedge clk);
		meas <= m;
	endtask

	task automatic check_afe_pins();
		logic exp_pickup;
		logic exp_sma;
		logic [vga_bits-1:0] exp_vga;
		exp_pickup = shadow[1][13] ? 1'b1 : cal_on;
		exp_sma = shadow[1][3] ? ~trig_out : 1'b1;
		exp_vga = shadow[1][6] ? auto_gain : shadow[88][4:0];
		check_count++;
		assert (afe_pickup === exp_pickup && afe_cal === ~exp_pickup && sma_out === exp_sma
				&& afe_vga_gain === exp_vga) else begin
			$display("Fail %0t: AFE pins pickup %b cal %b sma %b vga %h with ctrl %h", $time,
				afe_pickup, afe_cal, sma_out, afe_vga_gain, shadow[1][15:0]);
			err_count++;
		end
	endtask

	task automatic wait_att_value(input logic [att_bits-1:0] val, input int le_start);
		int n;
		n = 0;
		while (n < 100 && !(le_count > le_start && att_latched == val)) begin
			@(posedge clk);
			n++;
		end
		if (n >= 100) begin
			$display("Timeout: no attenuator latch of value %h", val);
			timeout_count++;
		end
	endtask

	//////////////////////////////
	// Compare processes
	//////////////////////////////
	always @(negedge clk) begin
		if (exp_q.size() > 0) begin
			check_count++;
			assert (rd_data === exp_q[0]) else begin
				$display("Fail %0t: rd_data %h, expected %h", $time, rd_data, exp_q[0]);
				err_count++;
			end
			void'(exp_q.pop_front());
		end
	end

	// Soft reset trails control bit 15 by one cycle
	always @(negedge clk) begin
		if (rst_n) begin
			assert (soft_rst === soft_exp) else begin
				$display("Fail %0t: soft_rst %b, expected %b", $time, soft_rst, soft_exp);
				err_count++;
			end
		end
		soft_exp = shadow[1][15];
	end

	// Serial attenuator capture on each att_clk rise
	always @(negedge clk) begin
		if (!rst_n) begin
			att_nbits = 0;
			le_count = 0;
			att_clk_q = 1'b0;
		end else begin
			if (att_clk && !att_clk_q) begin
				att_cap = {att_cap[att_bits-2:0], att_data};
				att_nbits++;
			end
			if (att_le) begin
				assert (att_nbits == att_bits) else begin
					$display("Fail %0t: %0d bits before att_le", $time, att_nbits);
					err_count++;
				end
				att_latched = att_cap;
				le_count++;
				att_nbits = 0;
			end
			att_clk_q = att_clk;
		end
	end

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		logic [15:0] w;
		logic [att_bits-1:0] att_a;
		logic [att_bits-1:0] att_b;
		logic [3:0] we_part;
		int le_start;
		lfsr = 32'hb923;
		bus = '0;
		meas = '0;
		trig_out = 1'b0;
		cal_on = 1'b0;
		auto_gain = '0;
		rst_n = 1'b0;
		check_count = 0;
		err_count = 0;
		timeout_count = 0;
		last_rd = '0;
		soft_exp = 1'b0;
		att_latched = '0;
		att_cap = '0;
		for (int i = 0; i < 128; i++) shadow[i] = '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_count++;
		assert (rd_data === '0 && !att_clk && !att_le && !att_data && !soft_rst) else begin
			$display("Fail %0t: outputs not cleared by reset", $time);
			err_count++;
		end

		// 16-bit registers and the version word
		for (int r = 0; r < 4; r++) begin
			foreach (regs16[i]) begin
				bus_write(regs16[i], 4'hf, rand_bits(32));
				bus_read(reg_addr(regs16[i]));
			end
			bus_read(reg_addr(2));
		end

		// Gains and measurement inputs
		for (int r = 0; r < 3; r++) begin
			for (int i = 96; i < 100; i++) begin
				bus_write(i, 4'hf, rand_bits(32));
				bus_read(reg_addr(i));
			end
			drive_meas();
			for (int i = 0; i <= 10; i++) bus_read(reg_addr(i));
		end

		// Partial strobes and unmapped reads
		for (int r = 0; r < 8; r++) begin
			we_part = 4'(rand_bits(4));
			if (we_part == 4'h0 || we_part == 4'hf) we_part = 4'h5;
			bus_write(regs16[r], we_part, rand_bits(32));
			bus_read(reg_addr(regs16[r]));
			bus_read(reg_addr(3 + r * 7));
		end
		bus_read(base_addr + 32'h1000);
		bus_read(base_addr - 32'd4);

		// Soft reset on and off
		bus_write(1, 4'hf, 32'h8000);
		bus_write(1, 4'hf, 32'h0000);
		repeat (2) @(posedge clk);

		// Single attenuator transfer, then two writes back to back
		att_a = 6'(rand_bits(6));
		if (att_a == shadow[88][13:8]) att_a = ~att_a;
		le_start = le_count;
		bus_write(88, 4'hf, {18'h0, att_a, 8'(rand_bits(8))});
		wait_att_value(att_a, le_start);
		att_b = att_a ^ 6'h2a;
		att_a = att_a ^ 6'h15;
		le_start = le_count;
		bus_write(88, 4'hf, {18'h0, att_a, 8'h0c});
		bus_write(88, 4'hf, {18'h0, att_b, 8'h13});
		wait_att_value(att_b, le_start);
		repeat (30) @(posedge clk);
		check_count++;
		assert (att_latched === att_b && !att_clk) else begin
			$display("Fail %0t: attenuator ended at %h, expected %h", $time, att_latched, att_b);
			err_count++;
		end

		// Front-end pins for all control combinations
		for (int m = 0; m < 8; m++) begin
			w = 16'(rand_bits(16));
			w[3] = m[0];
			w[6] = m[1];
			w[13] = m[2];
			bus_write(1, 4'hf, {16'h0, w});
			for (int k = 0; k < 4; k++) begin
				@(posedge clk);
				trig_out <= k[0];
				cal_on <= k[1];
				auto_gain <= 5'(rand_bits(5));
				@(negedge clk);
				check_afe_pins();
			end
		end

		repeat (3) @(posedge clk);
		if (exp_q.size() != 0) begin
			$display("Read checks left unanswered at the end of the run");
			err_count++;
		end
		$display("Checks %0d, errors %0d, timeouts %0d", check_count, err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== project.f ====
design/bpm_pkg.sv
design/bpm_bus_ctrl.sv
design/bpm_config_regs.sv
design/bpm_readback.sv
design/bpm_afe_ctrl.sv
design/bpm_top.sv
verif/tb_bpm_top.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_bpm_top -f project.f \
	-Mdir obj_dir -o tb_bpm_top_sim && ./obj_dir/tb_bpm_top_sim | tee sim.log
grep -q "TB PASSED" sim.log && echo "Simulation result: pass" || { echo "Simulation result: fail"; exit 1; }
